// File: compile.f
+incdir+.
sdio_data_pkg.sv
sdio_xfer_sequencer.sv
sdio_target_router.sv
sdio_data_control.sv
tb_sdio_data_control.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sdio_data_control \
  -f compile.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0

// File: tb_sdio_model.svh
////////////////////////////////////////////////////////////
// Reference model for the SDIO data controller testbench
// Tracks selected target, block length, byte count, address
////////////////////////////////////////////////////////////

`ifndef TB_SDIO_MODEL_SVH
`define TB_SDIO_MODEL_SVH

int    exp_sel;
cnt_t  exp_block_len;
int    exp_in_block;
addr_t exp_addr;
logic  exp_inc;

// Memory wins over the function number
function automatic int target_index(input logic mem_sel, input func_num_t func_sel);
  if (mem_sel) begin
    return int'(MEM_TARGET);
  end
  return int'(func_sel);
endfunction

// Byte mode with a zero count still moves one full block
function automatic cnt_t bytes_per_block(input xfer_cfg_t cfg);
  if (cfg.block_mode || cfg.data_cnt == '0) begin
    return cnt_t'(BLOCK_BYTES);
  end
  return cfg.data_cnt;
endfunction

task automatic expect_start(input xfer_cfg_t cfg, input logic mem_sel,
                            input func_num_t func_sel);
  exp_sel       = target_index(mem_sel, func_sel);
  exp_block_len = bytes_per_block(cfg);
  exp_in_block  = 0;
  exp_addr      = cfg.start_addr;
  exp_inc       = cfg.inc_addr;
endtask

// One counted byte
task automatic expect_beat();
  exp_in_block = exp_in_block + 1;
  if (exp_inc) begin
    exp_addr = exp_addr + addr_t'(1);
  end
endtask

function automatic logic block_full();
  return exp_in_block == int'(exp_block_len);
endfunction

`endif

// File: tb_sdio_data_control.sv
////////////////////////////////////////////////////////////
// Testbench for the SDIO card-side data controller
// Random transfers checked against a reference model
////////////////////////////////////////////////////////////

module tb_sdio_data_control;
  import sdio_data_pkg::*;

  localparam int TIMEOUT = 64;

  logic                        clk;
  logic                        rst;
  logic                        i_activate;
  xfer_cfg_t                   i_cfg;
  logic                        i_mem_sel;
  func_num_t                   i_func_sel;
  logic                        i_phy_wr_stb;
  byte_t                       i_phy_wr_data;
  func_bus_t [NUM_TARGETS-1:0] i_func;
  cnt_t                        o_total_data_cnt;
  addr_t                       o_address;
  logic                        o_finished;
  logic                        o_phy_rd_stb;
  byte_t                       o_phy_rd_data;
  logic                        o_phy_com_rdy;
  host_bus_t [NUM_TARGETS-1:0] o_func;

  integer seed = 32'h15a06086;
  string  test_name;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  logic   timed_out;

  `include "tb_sdio_model.svh"

  sdio_data_control u_dut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Drive point, just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_byte(input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_addr(input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_cnt(input cnt_t exp, input cnt_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic wait_hst_rdy(input logic level);
    int cycles;
    cycles = 0;
    while (!timed_out && o_func[exp_sel].hst_rdy !== level) begin
      tick();
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("%s: timed out waiting for hst_rdy to go %b", test_name, level);
        timed_out = 1'b1;
        test_errors++;
      end
    end
  endtask

  task automatic wait_finished();
    int cycles;
    cycles = 0;
    while (!timed_out && o_finished !== 1'b1) begin
      tick();
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("%s: timed out waiting for the finished flag", test_name);
        timed_out = 1'b1;
        test_errors++;
      end
    end
  endtask

  // Write side reaches only the selected target
  task automatic check_write_route(input byte_t data);
    for (int t = 0; t < NUM_TARGETS; t++) begin
      if (t == exp_sel) begin
        check_flag(1'b1, o_func[t].wr_stb);
        check_byte(data, o_func[t].wr_data);
        check_flag(1'b1, o_func[t].activate);
      end else begin
        check_flag(1'b0, o_func[t] != '0);
      end
    end
  endtask

  // Non-selected targets strobe constantly during reads
  task automatic set_read_noise(input logic on);
    for (int t = 0; t < NUM_TARGETS; t++) begin
      if (t != exp_sel) begin
        i_func[t].rd_stb  = on;
        i_func[t].rd_data = 8'ha5;
      end
    end
  endtask

  task automatic pick_target(output logic mem, output func_num_t fn);
    mem = (($random(seed) & 3) == 0);
    fn  = func_num_t'($random(seed));
  endtask

  function automatic xfer_cfg_t make_cfg(input logic blk, input cnt_t cnt, input logic inc);
    xfer_cfg_t cfg;
    cfg.block_mode = blk;
    cfg.data_cnt   = cnt;
    cfg.inc_addr   = inc;
    cfg.start_addr = addr_t'($random(seed));
    return cfg;
  endfunction

  task automatic start_xfer(input string name, input xfer_cfg_t cfg, input logic mem,
                            input func_num_t fn);
    test_name   = name;
    test_errors = 0;
    i_cfg       = cfg;
    i_mem_sel   = mem;
    i_func_sel  = fn;
    i_activate  = 1'b1;
    expect_start(cfg, mem, fn);
  endtask

  // Moves n bytes, with an occasional one-cycle stall from the target
  task automatic move_bytes(input logic is_read, input int n);
    byte_t data;
    for (int k = 0; k < n && !timed_out; k++) begin
      if (block_full()) begin
        wait_hst_rdy(1'b0);
        exp_in_block = 0;
      end
      wait_hst_rdy(1'b1);
      check_flag(1'b0, o_finished);
      if (($random(seed) & 3) == 0) begin
        i_func[exp_sel].com_rdy = 1'b0;
        #1;
        check_flag(1'b0, o_phy_com_rdy);
        tick();
        i_func[exp_sel].com_rdy = 1'b1;
      end
      data = byte_t'($random(seed));
      if (is_read) begin
        i_func[exp_sel].rd_stb  = 1'b1;
        i_func[exp_sel].rd_data = data;
      end else begin
        i_phy_wr_stb  = 1'b1;
        i_phy_wr_data = data;
      end
      #1;
      check_flag(1'b1, o_phy_com_rdy);
      if (is_read) begin
        check_flag(1'b1, o_phy_rd_stb);
        check_byte(data, o_phy_rd_data);
      end else begin
        check_write_route(data);
      end
      tick();
      i_phy_wr_stb            = 1'b0;
      i_func[exp_sel].rd_stb  = 1'b0;
      expect_beat();
    end
  endtask

  task automatic finish_test();
    i_activate = 1'b0;
    tick();
    tick();
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errors);
    end
  endtask

  initial begin
    xfer_cfg_t cfg;
    logic      mem;
    func_num_t fn;
    int        n;
    rst           = 1'b1;
    i_activate    = 1'b0;
    i_cfg         = '0;
    i_mem_sel     = 1'b0;
    i_func_sel    = '0;
    i_phy_wr_stb  = 1'b0;
    i_phy_wr_data = '0;
    i_func        = '0;
    for (int t = 0; t < NUM_TARGETS; t++) begin
      i_func[t].com_rdy = 1'b1;
    end
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name   = "reset";
    test_errors = 0;
    tick();
    check_flag(1'b0, o_finished);
    check_flag(1'b0, o_func != '0);
    check_flag(1'b0, o_phy_com_rdy);
    check_cnt('0, o_total_data_cnt);
    finish_test();

    pick_target(mem, fn);
    n   = 1 + ($random(seed) & 31);
    cfg = make_cfg(1'b0, cnt_t'(n), 1'b1);
    start_xfer("byte_write", cfg, mem, fn);
    move_bytes(1'b0, n);
    wait_finished();
    check_addr(exp_addr, o_address);
    check_cnt(cnt_t'(n), o_total_data_cnt);
    finish_test();

    pick_target(mem, fn);
    n   = 1 + ($random(seed) & 31);
    cfg = make_cfg(1'b0, cnt_t'(n), logic'($random(seed)));
    start_xfer("byte_read", cfg, mem, fn);
    set_read_noise(1'b1);
    move_bytes(1'b1, n);
    wait_finished();
    check_flag(1'b0, o_phy_com_rdy);
    check_addr(exp_addr, o_address);
    check_cnt(exp_block_len, o_total_data_cnt);
    set_read_noise(1'b0);
    finish_test();

    pick_target(mem, fn);
    start_xfer("byte_zero_count", make_cfg(1'b0, '0, 1'b1), mem, fn);
    move_bytes(1'b0, BLOCK_BYTES);
    wait_finished();
    check_cnt(cnt_t'(BLOCK_BYTES), o_total_data_cnt);
    check_addr(exp_addr, o_address);
    finish_test();

    pick_target(mem, fn);
    cfg = make_cfg(1'b1, cnt_t'(2), 1'b0);
    start_xfer("two_blocks", cfg, mem, fn);
    move_bytes(1'b0, 2 * BLOCK_BYTES);
    wait_finished();
    check_addr(cfg.start_addr, o_address);
    finish_test();

    pick_target(mem, fn);
    start_xfer("continuous", make_cfg(1'b1, '0, 1'b1), mem, fn);
    move_bytes(1'b0, 3 * BLOCK_BYTES);
    wait_hst_rdy(1'b0);
    check_addr(exp_addr, o_address);
    repeat (4) begin
      tick();
      check_flag(1'b0, o_finished);
    end
    // Abort, then IDLE picks up the new start address
    cfg              = make_cfg(1'b1, '0, 1'b1);
    i_cfg.start_addr = cfg.start_addr;
    i_activate       = 1'b0;
    repeat (2) begin
      tick();
      check_flag(1'b0, o_finished);
    end
    check_addr(cfg.start_addr, o_address);
    finish_test();

    $display("%0d of %0d tests ok, %0d checks failed",
             tests_run - tests_failed, tests_run, errors);
    if (errors == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: sdio_data_control.sv
////////////////////////////////////////////////////////////
// SDIO card-side data controller
// Transfer sequencer plus router to CIA, functions and memory
////////////////////////////////////////////////////////////

module sdio_data_control (
  input  logic                      clk,
  input  logic                      rst,

  // Host side request
  input  logic                      i_activate,
  input  sdio_data_pkg::xfer_cfg_t  i_cfg,
  input  logic                      i_mem_sel,
  input  sdio_data_pkg::func_num_t  i_func_sel,
  output sdio_data_pkg::cnt_t       o_total_data_cnt,
  output sdio_data_pkg::addr_t      o_address,
  output logic                      o_finished,

  // Data PHY byte stream
  input  logic                      i_phy_wr_stb,
  input  sdio_data_pkg::byte_t      i_phy_wr_data,
  output logic                      o_phy_rd_stb,
  output sdio_data_pkg::byte_t      o_phy_rd_data,
  output logic                      o_phy_com_rdy,

  // CIA at 0, functions 1 to 7, memory at 8
  input  sdio_data_pkg::func_bus_t [sdio_data_pkg::NUM_TARGETS-1:0] i_func,
  output sdio_data_pkg::host_bus_t [sdio_data_pkg::NUM_TARGETS-1:0] o_func
);

  logic ready;
  logic beat;

  sdio_xfer_sequencer u_seq (
    .clk              (clk),
    .rst              (rst),
    .i_activate       (i_activate),
    .i_cfg            (i_cfg),
    .i_beat           (beat),
    .o_ready          (ready),
    .o_total_data_cnt (o_total_data_cnt),
    .o_address        (o_address),
    .o_finished       (o_finished)
  );

  // Purely combinational, no clock needed
  sdio_target_router u_router (
    .i_mem_sel     (i_mem_sel),
    .i_func_sel    (i_func_sel),
    .i_activate    (i_activate),
    .i_ready       (ready),
    .i_phy_wr_stb  (i_phy_wr_stb),
    .i_phy_wr_data (i_phy_wr_data),
    .i_func        (i_func),
    .o_func        (o_func),
    .o_phy_rd_stb  (o_phy_rd_stb),
    .o_phy_rd_data (o_phy_rd_data),
    .o_phy_com_rdy (o_phy_com_rdy),
    .o_beat        (beat)
  );

endmodule

// File: sdio_target_router.sv
////////////////////////////////////////////////////////////
// SDIO target router
// Steers the PHY byte stream to and from the selected target
////////////////////////////////////////////////////////////

module sdio_target_router (
  input  logic                      i_mem_sel,
  input  sdio_data_pkg::func_num_t  i_func_sel,
  input  logic                      i_activate,
  input  logic                      i_ready,
  input  logic                      i_phy_wr_stb,
  input  sdio_data_pkg::byte_t      i_phy_wr_data,
  input  sdio_data_pkg::func_bus_t [sdio_data_pkg::NUM_TARGETS-1:0] i_func,
  output sdio_data_pkg::host_bus_t [sdio_data_pkg::NUM_TARGETS-1:0] o_func,
  output logic                      o_phy_rd_stb,
  output sdio_data_pkg::byte_t      o_phy_rd_data,
  output logic                      o_phy_com_rdy,
  output logic                      o_beat
);
  import sdio_data_pkg::*;

  target_t   target_sel;
  host_bus_t host_bus;
  func_bus_t sel_bus;

  // Memory overrides the function number, function 0 is the CIA
  assign target_sel = i_mem_sel ? MEM_TARGET : {1'b0, i_func_sel};

  // Write side bundle for whichever target is selected
  always_comb begin
    host_bus.wr_stb   = i_phy_wr_stb;
    host_bus.wr_data  = i_phy_wr_data;
    host_bus.hst_rdy  = i_ready;
    host_bus.activate = i_activate;
  end

  // Unselected targets see an idle bus
  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (target_sel == target_t'(i)) begin
        o_func[i] = host_bus;
      end else begin
        o_func[i] = '0;
      end
    end
  end

  // Read side back to the PHY
  always_comb begin
    sel_bus = '0;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (target_sel == target_t'(i)) begin
        sel_bus = i_func[i];
      end
    end
  end

  assign o_phy_rd_stb  = sel_bus.rd_stb;
  assign o_phy_rd_data = sel_bus.rd_data;

  // Target must be ready and the sequencer inside a block
  assign o_phy_com_rdy = sel_bus.com_rdy & i_ready;

  // A byte moved in either direction this cycle
  assign o_beat = i_phy_wr_stb | sel_bus.rd_stb;

endmodule

// File: sdio_xfer_sequencer.sv
////////////////////////////////////////////////////////////
// SDIO transfer sequencer
// Counts bytes and blocks, steps the address, flags the end
////////////////////////////////////////////////////////////

module sdio_xfer_sequencer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_activate,
  input  sdio_data_pkg::xfer_cfg_t i_cfg,
  input  logic                     i_beat,
  output logic                     o_ready,
  output sdio_data_pkg::cnt_t      o_total_data_cnt,
  output sdio_data_pkg::addr_t     o_address,
  output logic                     o_finished
);
  import sdio_data_pkg::*;

  xfer_state_t            state;
  cnt_t                   data_count;
  logic [BLOCK_CNT_W-1:0] block_count;
  logic [BLOCK_CNT_W-1:0] total_block_count;
  logic                   continuous;
  logic                   in_block;
  logic                   more_blocks;

  // Still bytes left in the current block
  assign in_block = (data_count < o_total_data_cnt);

  // Continuous transfers only stop when activate drops
  assign more_blocks = continuous || (block_count < total_block_count);

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= IDLE;
      o_ready           <= 1'b0;
      o_finished        <= 1'b0;
      o_total_data_cnt  <= '0;
      o_address         <= '0;
      data_count        <= '0;
      block_count       <= '0;
      total_block_count <= '0;
      continuous        <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          o_ready          <= 1'b0;
          o_finished       <= 1'b0;
          o_total_data_cnt <= '0;
          data_count       <= '0;
          block_count      <= '0;
          o_address        <= i_cfg.start_addr;
          // Block mode with a zero count never ends by itself
          continuous       <= i_cfg.block_mode && (i_cfg.data_cnt == '0);
          if (i_cfg.block_mode) begin
            total_block_count <= i_cfg.data_cnt[BLOCK_CNT_W-1:0];
          end else begin
            total_block_count <= '0;
          end
          if (i_activate) begin
            state <= CONFIG;
          end
        end

        CONFIG: begin
          // New block, restart the byte count
          data_count <= '0;
          if (i_cfg.block_mode) begin
            o_total_data_cnt <= cnt_t'(BLOCK_BYTES);
            if (!continuous) begin
              block_count <= block_count + 1'b1;
            end
          end else if (i_cfg.data_cnt == '0) begin
            o_total_data_cnt <= cnt_t'(BLOCK_BYTES);
          end else begin
            o_total_data_cnt <= i_cfg.data_cnt;
          end
          state <= ACTIVE;
        end

        ACTIVE: begin
          if (in_block) begin
            o_ready <= 1'b1;
            if (i_beat) begin
              data_count <= data_count + 1'b1;
              if (i_cfg.inc_addr) begin
                o_address <= o_address + 1'b1;
              end
            end
          end else begin
            // Block done, hold off the PHY until reconfigured
            o_ready <= 1'b0;
            if (more_blocks) begin
              state <= CONFIG;
            end else begin
              state <= FINISHED;
            end
          end
        end

        FINISHED: begin
          o_finished <= 1'b1;
        end
      endcase

      // Dropping activate aborts from any state
      if (!i_activate) begin
        state <= IDLE;
      end
    end
  end

endmodule

// File: sdio_data_pkg.sv
////////////////////////////////////////////////////////////
// SDIO data controller shared definitions
// Widths, transfer state and per-target bus structs
////////////////////////////////////////////////////////////

package sdio_data_pkg;

  // Data path and address widths
  localparam int BYTE_W = 8;
  localparam int ADDR_W = 18;

  // Transfer length as given by the command
  localparam int CNT_W = 13;

  // Blocks tracked inside the sequencer
  localparam int BLOCK_CNT_W = 10;

  // One block, also the byte count when the command gives zero
  localparam int BLOCK_BYTES = 512;

  // CIA, functions 1 to 7 and card memory
  localparam int NUM_TARGETS = 9;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [3:0]        target_t;
  typedef logic [2:0]        func_num_t;

  // Memory sits after the seven functions
  localparam target_t MEM_TARGET = target_t'(8);

  typedef enum logic [1:0] {
    IDLE,
    CONFIG,
    ACTIVE,
    FINISHED
  } xfer_state_t;

  // Transfer request from the command layer
  typedef struct packed {
    logic  block_mode;
    cnt_t  data_cnt;
    logic  inc_addr;
    addr_t start_addr;
  } xfer_cfg_t;

  // Controller toward one target
  typedef struct packed {
    logic  wr_stb;
    byte_t wr_data;
    logic  hst_rdy;
    logic  activate;
  } host_bus_t;

  // One target back toward the controller
  typedef struct packed {
    logic  rd_stb;
    byte_t rd_data;
    logic  com_rdy;
  } func_bus_t;

endpackage
